// File: common/core_cfg_pkg.sv
package core_cfg_pkg;
    import rv_isa_pkg::*;

    localparam int unsigned XLEN = 32;

    typedef logic [4:0]      reg_addr_t;
    typedef logic [XLEN-1:0] xlen_t;

    // ID/EX entry
    typedef struct packed {
        operation_e op;
        xlen_t      imm;
        logic [4:0] shamt;
        reg_addr_t  rs1;
        reg_addr_t  rs2;
        reg_addr_t  rd;
        logic       we;
    } decoded_instr_t;

    // EX/WB entry
    typedef struct packed {
        reg_addr_t rd;
        xlen_t     result;
        logic      we;
    } retire_t;

endpackage

// File: common/rv_isa_pkg.sv
package rv_isa_pkg;

    // RV32 instruction word width
    localparam int unsigned ILEN = 32;

    // Major opcodes
    localparam logic [6:0] OPCODE_LUI    = 7'b0110111;
    localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPCODE_OP     = 7'b0110011;

    // funct3, shared by OP and OP-IMM
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // funct7
    localparam logic [6:0] F7_BASE      = 7'b0000000;
    localparam logic [6:0] F7_ALT       = 7'b0100000;
    localparam logic [6:0] F7_ZBB_COUNT = 7'b0110000;

    // Zbb count select, sits in the rs2 field
    localparam logic [4:0] F5_CLZ  = 5'b00000;
    localparam logic [4:0] F5_CTZ  = 5'b00001;
    localparam logic [4:0] F5_CPOP = 5'b00010;

    typedef enum logic [5:0] {
        OPERATION_UNKNOWN = 6'd0,
        LUI,
        ADDI,
        SLTI,
        SLTIU,
        XORI,
        ORI,
        ANDI,
        SLLI,
        SRLI,
        SRAI,
        ADD,
        SUB,
        SLL,
        SLT,
        SLTU,
        XOR,
        OR,
        AND,
        SRL,
        SRA,
        CLZ,
        CTZ,
        CPOP
    } operation_e;

    function automatic logic [ILEN-1:0] get_i_type_imm(logic [ILEN-1:0] instr);
        return {{20{instr[31]}}, instr[31:20]};
    endfunction

    function automatic logic [ILEN-1:0] get_u_type_imm(logic [ILEN-1:0] instr);
        return {instr[31:12], 12'b0};
    endfunction

endpackage

// File: common/stage_if.sv
`timescale 1ns/1ps

interface stage_if #(
    parameter type payload_t = logic
) ();

    logic     valid;
    logic     ready;
    payload_t payload;

    modport producer (
        output valid,
        output payload,
        input  ready
    );

    modport consumer (
        input  valid,
        input  payload,
        output ready
    );

    // Observe only, e.g. the retire entry seen by the execute stage
    modport monitor (
        input valid,
        input payload,
        input ready
    );

endinterface

// File: dv/rv_alu_core_chk.sv
`timescale 1ns/1ps

module rv_alu_core_chk
    import rv_isa_pkg::*;
    import core_cfg_pkg::*;
(
    input logic       clk,
    input logic       rstn,
    input logic       retire_valid_i,
    input logic       retire_ready_i,
    input reg_addr_t  retire_rd_i,
    input xlen_t      retire_data_i,
    input logic       retire_we_i,
    input logic       ex_valid_i,
    input logic       ex_ready_i,
    input operation_e ex_op_i
);

    int assert_fail_count = 0;

    // A stalled retire entry must not move
    retire_hold: assert property (
        @(posedge clk) disable iff (!rstn)
        retire_valid_i && !retire_ready_i |=>
            retire_valid_i && $stable(retire_rd_i) && $stable(retire_data_i) &&
            $stable(retire_we_i)
    ) else begin
        assert_fail_count++;
        $error("retire entry changed while retire_ready_i was low");
    end

    retire_idle_in_reset: assert property (
        @(posedge clk) !rstn |-> !retire_valid_i
    ) else begin
        assert_fail_count++;
        $error("retire_valid_o high during reset");
    end

    // Only unknown decodes reach the retire entry without a register write
    write_enable_known_op: assert property (
        @(posedge clk) disable iff (!rstn)
        ex_valid_i && ex_ready_i |=>
            (retire_we_i == ($past(ex_op_i) != OPERATION_UNKNOWN))
    ) else begin
        assert_fail_count++;
        $error("retire write enable does not match decoded operation");
    end

endmodule

// File: dv/rv_alu_core_scoreboard.sv
`timescale 1ns/1ps

module rv_alu_core_scoreboard
    import core_cfg_pkg::*;
(
    input  logic      clk,
    input  logic      rstn,
    input  logic      instr_valid_i,
    input  logic      instr_ready_i,
    input  reg_addr_t exp_rd_i,
    input  xlen_t     exp_data_i,
    input  logic      exp_we_i,
    input  logic      retire_valid_i,
    input  logic      retire_ready_i,
    input  reg_addr_t retire_rd_i,
    input  xlen_t     retire_data_i,
    input  logic      retire_we_i,
    output int        mismatch_count_o,
    output int        unexpected_count_o,
    output int        pending_o
);

    retire_t expected_q [$];
    retire_t expected;
    int      retire_idx;

    initial begin
        mismatch_count_o   = 0;
        unexpected_count_o = 0;
        pending_o          = 0;
        retire_idx         = 0;
    end

    always @(posedge clk) begin
        if (rstn && retire_valid_i && retire_ready_i) begin
            if (expected_q.size() == 0) begin
                $display("Retire of rd %0d at %0t with no instruction outstanding",
                         retire_rd_i, $time);
                unexpected_count_o++;
            end else begin
                expected = expected_q.pop_front();
                if (retire_rd_i !== expected.rd) begin
                    $display("** Error: retire_rd_o = 0x%02h, expected 0x%02h (entry %0d)",
                             retire_rd_i, expected.rd, retire_idx);
                    mismatch_count_o++;
                end
                if (retire_we_i !== expected.we) begin
                    $display("** Error: retire_we_o = 0x%01h, expected 0x%01h (entry %0d)",
                             retire_we_i, expected.we, retire_idx);
                    mismatch_count_o++;
                end
                // Data of a non-writing entry carries no meaning
                if (expected.we && (retire_data_i !== expected.result)) begin
                    $display("** Error: retire_data_o = 0x%08h, expected 0x%08h (entry %0d)",
                             retire_data_i, expected.result, retire_idx);
                    mismatch_count_o++;
                end
            end
            retire_idx++;
        end
        if (rstn && instr_valid_i && instr_ready_i) begin
            expected_q.push_back(retire_t'{rd: exp_rd_i, result: exp_data_i, we: exp_we_i});
        end
        pending_o = expected_q.size();
    end

endmodule

// File: dv/rv_alu_core_tb.sv
`timescale 1ns/1ps

module rv_alu_core_tb
    import rv_isa_pkg::*;
    import core_cfg_pkg::*;
();

    localparam int CLK_PERIOD     = 20;
    localparam int NUM_ENTRIES    = 31;
    localparam int TIMEOUT_CYCLES = NUM_ENTRIES * 10 + 100;

    logic      clk;
    logic      rstn;
    logic      instr_valid_i;
    xlen_t     instr_i;
    logic      instr_ready_o;
    logic      retire_valid_o;
    reg_addr_t retire_rd_o;
    xlen_t     retire_data_o;
    logic      retire_we_o;
    logic      retire_ready_i;

    reg_addr_t exp_rd;
    xlen_t     exp_data;
    logic      exp_we;
    logic      drain;
    int        cycle_count;
    int        fill_idx;
    int        mismatch_count;
    int        unexpected_count;
    int        pending;
    int        assert_errors;

    xlen_t     tbl_instr [NUM_ENTRIES];
    reg_addr_t tbl_rd    [NUM_ENTRIES];
    xlen_t     tbl_data  [NUM_ENTRIES];
    logic      tbl_we    [NUM_ENTRIES];
    logic      ready_pattern [TIMEOUT_CYCLES];

    rv_alu_core i_rv_alu_core (
        .clk            (clk),
        .rstn           (rstn),
        .instr_valid_i  (instr_valid_i),
        .instr_i        (instr_i),
        .instr_ready_o  (instr_ready_o),
        .retire_valid_o (retire_valid_o),
        .retire_rd_o    (retire_rd_o),
        .retire_data_o  (retire_data_o),
        .retire_we_o    (retire_we_o),
        .retire_ready_i (retire_ready_i)
    );

    rv_alu_core_scoreboard i_scoreboard (
        .clk                (clk),
        .rstn               (rstn),
        .instr_valid_i      (instr_valid_i),
        .instr_ready_i      (instr_ready_o),
        .exp_rd_i           (exp_rd),
        .exp_data_i         (exp_data),
        .exp_we_i           (exp_we),
        .retire_valid_i     (retire_valid_o),
        .retire_ready_i     (retire_ready_i),
        .retire_rd_i        (retire_rd_o),
        .retire_data_i      (retire_data_o),
        .retire_we_i        (retire_we_o),
        .mismatch_count_o   (mismatch_count),
        .unexpected_count_o (unexpected_count),
        .pending_o          (pending)
    );

    bind rv_alu_core rv_alu_core_chk i_chk (
        .clk            (clk),
        .rstn           (rstn),
        .retire_valid_i (retire_valid_o),
        .retire_ready_i (retire_ready_i),
        .retire_rd_i    (retire_rd_o),
        .retire_data_i  (retire_data_o),
        .retire_we_i    (retire_we_o),
        .ex_valid_i     (ex_if.valid),
        .ex_ready_i     (ex_if.ready),
        .ex_op_i        (ex_if.payload.op)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic xlen_t encode_u_type(reg_addr_t rd, logic [19:0] imm);
        return {imm, rd, OPCODE_LUI};
    endfunction

    function automatic xlen_t encode_i_type(logic [2:0] f3, reg_addr_t rd, reg_addr_t rs1,
                                            logic [11:0] imm);
        return {imm, rs1, f3, rd, OPCODE_OP_IMM};
    endfunction

    function automatic xlen_t encode_r_type(logic [6:0] f7, logic [2:0] f3, reg_addr_t rd,
                                            reg_addr_t rs1, reg_addr_t rs2);
        return {f7, rs2, rs1, f3, rd, OPCODE_OP};
    endfunction

    task automatic add_entry(input xlen_t instr, input reg_addr_t rd, input xlen_t data,
                             input logic we);
        tbl_instr[fill_idx] = instr;
        tbl_rd[fill_idx]    = rd;
        tbl_data[fill_idx]  = data;
        tbl_we[fill_idx]    = we;
        fill_idx++;
    endtask

    // Each result feeds a later operand, mostly the very next one
    task automatic load_table();
        add_entry(encode_u_type(1, 20'h12345), 1, 32'h12345000, 1);
        add_entry(encode_i_type(F3_ADD_SUB, 2, 1, 12'h678), 2, 32'h12345678, 1);
        add_entry(encode_i_type(F3_ADD_SUB, 3, 0, 12'hFFF), 3, 32'hFFFFFFFF, 1);
        add_entry(encode_i_type(F3_SLT, 4, 3, 12'h000), 4, 32'h00000001, 1);
        add_entry(encode_i_type(F3_SLTU, 5, 3, 12'h001), 5, 32'h00000000, 1);
        add_entry(encode_i_type(F3_SLTU, 6, 0, 12'hFFF), 6, 32'h00000001, 1);
        add_entry(encode_i_type(F3_XOR, 7, 2, 12'hFFF), 7, 32'hEDCBA987, 1);
        add_entry(encode_i_type(F3_OR, 8, 7, 12'h0F0), 8, 32'hEDCBA9F7, 1);
        add_entry(encode_i_type(F3_AND, 9, 8, 12'h7FF), 9, 32'h000001F7, 1);
        add_entry(encode_i_type(F3_SLL, 10, 9, {F7_BASE, 5'd4}), 10, 32'h00001F70, 1);
        add_entry(encode_i_type(F3_SRL_SRA, 11, 7, {F7_BASE, 5'd8}), 11, 32'h00EDCBA9, 1);
        add_entry(encode_i_type(F3_SRL_SRA, 12, 7, {F7_ALT, 5'd8}), 12, 32'hFFEDCBA9, 1);
        add_entry(encode_r_type(F7_BASE, F3_ADD_SUB, 13, 12, 11), 13, 32'h00DB9752, 1);
        add_entry(encode_r_type(F7_ALT, F3_ADD_SUB, 14, 11, 12), 14, 32'h01000000, 1);
        add_entry(encode_r_type(F7_BASE, F3_SLL, 15, 2, 9), 15, 32'h3C000000, 1);
        add_entry(encode_r_type(F7_ALT, F3_SRL_SRA, 16, 7, 10), 16, 32'hFFFFEDCB, 1);
        add_entry(encode_r_type(F7_BASE, F3_SRL_SRA, 17, 7, 10), 17, 32'h0000EDCB, 1);
        add_entry(encode_r_type(F7_BASE, F3_SLT, 18, 16, 17), 18, 32'h00000001, 1);
        add_entry(encode_r_type(F7_BASE, F3_SLTU, 19, 16, 17), 19, 32'h00000000, 1);
        add_entry(encode_r_type(F7_BASE, F3_XOR, 20, 16, 17), 20, 32'hFFFF0000, 1);
        add_entry(encode_r_type(F7_BASE, F3_OR, 21, 20, 1), 21, 32'hFFFF5000, 1);
        add_entry(encode_r_type(F7_BASE, F3_AND, 22, 21, 2), 22, 32'h12345000, 1);
        add_entry(encode_i_type(F3_SLL, 23, 22, {F7_ZBB_COUNT, F5_CLZ}), 23, 32'd3, 1);
        add_entry(encode_i_type(F3_SLL, 24, 22, {F7_ZBB_COUNT, F5_CTZ}), 24, 32'd12, 1);
        add_entry(encode_i_type(F3_SLL, 25, 22, {F7_ZBB_COUNT, F5_CPOP}), 25, 32'd7, 1);
        add_entry(encode_i_type(F3_SLL, 26, 0, {F7_ZBB_COUNT, F5_CLZ}), 26, 32'd32, 1);
        add_entry(encode_i_type(F3_SLL, 27, 0, {F7_ZBB_COUNT, F5_CTZ}), 27, 32'd32, 1);
        // Write to x0 right before a read of x0
        add_entry(encode_i_type(F3_ADD_SUB, 0, 1, 12'h005), 0, 32'h12345005, 1);
        add_entry(encode_r_type(F7_BASE, F3_ADD_SUB, 28, 0, 0), 28, 32'h00000000, 1);
        // Unknown opcode aimed at x4, x4 must keep its value
        add_entry(32'h0000027F, 4, 32'h00000000, 0);
        add_entry(encode_i_type(F3_ADD_SUB, 29, 4, 12'h001), 29, 32'h00000002, 1);
    endtask

    task automatic send_instr(input int idx);
        instr_valid_i = 1'b1;
        instr_i       = tbl_instr[idx];
        exp_rd        = tbl_rd[idx];
        exp_data      = tbl_data[idx];
        exp_we        = tbl_we[idx];
        @(negedge clk);
        while (!instr_ready_o) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        instr_valid_i = 1'b0;
    endtask

    always @(posedge clk) begin
        #1;
        if (drain) begin
            retire_ready_i = 1'b1;
        end else begin
            retire_ready_i = ready_pattern[cycle_count % TIMEOUT_CYCLES];
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, %0d accepted instructions never retired",
                     TIMEOUT_CYCLES, pending);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        int idle;
        void'($urandom(70867));
        clk            = 1'b0;
        rstn           = 1'b0;
        instr_valid_i  = 1'b0;
        instr_i        = '0;
        retire_ready_i = 1'b0;
        exp_rd         = '0;
        exp_data       = '0;
        exp_we         = 1'b0;
        drain          = 1'b0;
        cycle_count    = 0;
        fill_idx       = 0;
        assert_errors  = 0;
        // Retire port stalls about 30% of cycles
        for (int c = 0; c < TIMEOUT_CYCLES; c++) begin
            ready_pattern[c] = ($urandom % 10) >= 3;
        end
        load_table();
        repeat (4) @(posedge clk);
        #1;
        rstn = 1'b1;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            idle = (($urandom % 4) == 0) ? ($urandom % 3) + 1 : 0;
            repeat (idle) begin
                @(posedge clk);
                #1;
            end
            send_instr(i);
        end
        drain = 1'b1;
        wait (pending == 0);
        repeat (10) @(posedge clk);
        assert_errors = i_rv_alu_core.i_chk.assert_fail_count;
        $display("Errors: %0d mismatches, %0d unexpected, %0d missing, %0d assertion failures",
                 mismatch_count, unexpected_count, pending, assert_errors);
        if ((mismatch_count + unexpected_count + pending + assert_errors) == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: project.f
common/rv_isa_pkg.sv
common/core_cfg_pkg.sv
common/stage_if.sv
verilog/rv_decode_stage.sv
verilog/pipe_stage.sv
verilog/reg_file.sv
verilog/rv_execute_stage.sv
verilog/rv_alu_core.sv
dv/rv_alu_core_chk.sv
dv/rv_alu_core_scoreboard.sv
dv/rv_alu_core_tb.sv

// File: verilog/pipe_stage.sv
`timescale 1ns/1ps

module pipe_stage #(
    parameter type payload_t = logic
) (
    input  logic      clk,
    input  logic      rstn,
    stage_if.consumer in_i,
    stage_if.producer out_o
);

    logic     valid_q;
    payload_t data_q;

    // Take new data when empty or when the held entry leaves this cycle
    assign in_i.ready = !valid_q || out_o.ready;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid_q <= 1'b0;
        end else if (in_i.ready) begin
            valid_q <= in_i.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_i.valid && in_i.ready) begin
            data_q <= in_i.payload;
        end
    end

    assign out_o.valid   = valid_q;
    assign out_o.payload = data_q;

endmodule

// File: verilog/reg_file.sv
`timescale 1ns/1ps

module reg_file
    import core_cfg_pkg::*;
(
    input  logic      clk,
    input  logic      rstn,
    input  reg_addr_t rs1_addr_i,
    input  reg_addr_t rs2_addr_i,
    output xlen_t     rs1_data_o,
    output xlen_t     rs2_data_o,
    input  logic      we_i,
    input  reg_addr_t rd_i,
    input  xlen_t     rd_data_i
);

    // x0 has no storage
    xlen_t regs [31:1];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (rd_i != '0)) begin
            regs[rd_i] <= rd_data_i;
        end
    end

    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

endmodule

// File: verilog/rv_alu_core.sv
`timescale 1ns/1ps

module rv_alu_core
    import core_cfg_pkg::*;
(
    input  logic      clk,
    input  logic      rstn,
    input  logic      instr_valid_i,
    input  xlen_t     instr_i,
    output logic      instr_ready_o,
    output logic      retire_valid_o,
    output reg_addr_t retire_rd_o,
    output xlen_t     retire_data_o,
    output logic      retire_we_o,
    input  logic      retire_ready_i
);

    stage_if #(.payload_t(decoded_instr_t)) dec_if ();
    stage_if #(.payload_t(decoded_instr_t)) ex_if ();
    stage_if #(.payload_t(retire_t))        res_if ();
    stage_if #(.payload_t(retire_t))        wb_if ();

    rv_decode_stage i_decode (
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .instr_ready_o (instr_ready_o),
        .dec_o         (dec_if)
    );

    // ID/EX register
    pipe_stage #(
        .payload_t (decoded_instr_t)
    ) i_id_ex (
        .clk   (clk),
        .rstn  (rstn),
        .in_i  (dec_if),
        .out_o (ex_if)
    );

    rv_execute_stage i_execute (
        .clk   (clk),
        .rstn  (rstn),
        .ex_i  (ex_if),
        .res_o (res_if),
        .wb_i  (wb_if)
    );

    // EX/WB register, its output is the retire port
    pipe_stage #(
        .payload_t (retire_t)
    ) i_ex_wb (
        .clk   (clk),
        .rstn  (rstn),
        .in_i  (res_if),
        .out_o (wb_if)
    );

    assign retire_valid_o = wb_if.valid;
    assign retire_rd_o    = wb_if.payload.rd;
    assign retire_data_o  = wb_if.payload.result;
    assign retire_we_o    = wb_if.payload.we;
    assign wb_if.ready    = retire_ready_i;

endmodule

// File: verilog/rv_decode_stage.sv
`timescale 1ns/1ps

module rv_decode_stage
    import rv_isa_pkg::*;
    import core_cfg_pkg::*;
(
    input  logic     instr_valid_i,
    input  xlen_t    instr_i,
    output logic     instr_ready_o,
    stage_if.producer dec_o
);

    logic [6:0]     opcode;
    logic [2:0]     funct3;
    logic [6:0]     funct7;
    logic [4:0]     funct5;
    decoded_instr_t dec;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];
    assign funct5 = instr_i[24:20];

    // Pure combinational stage, handshake passes straight through
    assign dec_o.valid   = instr_valid_i;
    assign instr_ready_o = dec_o.ready;
    assign dec_o.payload = dec;

    always_comb begin
        dec       = '0;
        dec.op    = OPERATION_UNKNOWN;
        dec.rd    = instr_i[11:7];
        dec.rs1   = instr_i[19:15];
        dec.rs2   = instr_i[24:20];
        dec.shamt = instr_i[24:20];

        case (opcode)
            OPCODE_LUI: begin
                dec.imm = get_u_type_imm(instr_i);
                dec.op  = LUI;
            end
            OPCODE_OP_IMM: begin
                dec.imm = get_i_type_imm(instr_i);
                case (funct3)
                    F3_ADD_SUB: dec.op = ADDI;
                    F3_SLT:     dec.op = SLTI;
                    F3_SLTU:    dec.op = SLTIU;
                    F3_XOR:     dec.op = XORI;
                    F3_OR:      dec.op = ORI;
                    F3_AND:     dec.op = ANDI;
                    F3_SLL: begin
                        if (funct7 == F7_BASE) begin
                            dec.op = SLLI;
                        end else if (funct7 == F7_ZBB_COUNT) begin
                            case (funct5)
                                F5_CLZ:  dec.op = CLZ;
                                F5_CTZ:  dec.op = CTZ;
                                F5_CPOP: dec.op = CPOP;
                                default: ;
                            endcase
                        end
                    end
                    F3_SRL_SRA: begin
                        if (funct7 == F7_BASE) begin
                            dec.op = SRLI;
                        end else if (funct7 == F7_ALT) begin
                            dec.op = SRAI;
                        end
                    end
                    default: ;
                endcase
            end
            OPCODE_OP: begin
                if (funct7 == F7_BASE) begin
                    case (funct3)
                        F3_ADD_SUB: dec.op = ADD;
                        F3_SLL:     dec.op = SLL;
                        F3_SLT:     dec.op = SLT;
                        F3_SLTU:    dec.op = SLTU;
                        F3_XOR:     dec.op = XOR;
                        F3_SRL_SRA: dec.op = SRL;
                        F3_OR:      dec.op = OR;
                        F3_AND:     dec.op = AND;
                        default: ;
                    endcase
                end else if (funct7 == F7_ALT) begin
                    case (funct3)
                        F3_ADD_SUB: dec.op = SUB;
                        F3_SRL_SRA: dec.op = SRA;
                        default: ;
                    endcase
                end
            end
            default: ;
        endcase

        // Unknown encodings still flow down and retire, without a write
        dec.we = (dec.op != OPERATION_UNKNOWN);
    end

endmodule

// File: verilog/rv_execute_stage.sv
`timescale 1ns/1ps

module rv_execute_stage
    import rv_isa_pkg::*;
    import core_cfg_pkg::*;
(
    input  logic      clk,
    input  logic      rstn,
    stage_if.consumer ex_i,
    stage_if.producer res_o,
    stage_if.monitor  wb_i
);

    decoded_instr_t ex;
    retire_t        wb;
    xlen_t          rs1_data;
    xlen_t          rs2_data;
    xlen_t          op_a;
    xlen_t          op_b;
    xlen_t          result;
    logic           wb_pending;

    function automatic xlen_t count_lead_zeros(xlen_t v);
        xlen_t n;
        n = xlen_t'(XLEN);
        // Highest set bit wins since it is visited last
        for (int i = 0; i < XLEN; i++) begin
            if (v[i]) begin
                n = xlen_t'(XLEN - 1 - i);
            end
        end
        return n;
    endfunction

    function automatic xlen_t count_trail_zeros(xlen_t v);
        xlen_t n;
        n = xlen_t'(XLEN);
        for (int i = XLEN - 1; i >= 0; i--) begin
            if (v[i]) begin
                n = xlen_t'(i);
            end
        end
        return n;
    endfunction

    function automatic xlen_t count_ones(xlen_t v);
        xlen_t n;
        n = '0;
        for (int i = 0; i < XLEN; i++) begin
            n = n + xlen_t'(v[i]);
        end
        return n;
    endfunction

    assign ex = ex_i.payload;
    assign wb = wb_i.payload;

    reg_file i_reg_file (
        .clk        (clk),
        .rstn       (rstn),
        .rs1_addr_i (ex.rs1),
        .rs2_addr_i (ex.rs2),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .we_i       (wb_i.valid && wb_i.ready && wb.we),
        .rd_i       (wb.rd),
        .rd_data_i  (wb.result)
    );

    // Retire entry is the only result not yet in the register file
    assign wb_pending = wb_i.valid && wb.we && (wb.rd != '0);
    assign op_a = (wb_pending && (wb.rd == ex.rs1)) ? wb.result : rs1_data;
    assign op_b = (wb_pending && (wb.rd == ex.rs2)) ? wb.result : rs2_data;

    always_comb begin
        result = '0;
        case (ex.op)
            LUI:   result = ex.imm;
            ADDI:  result = op_a + ex.imm;
            SLTI:  result = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(ex.imm)};
            SLTIU: result = {{(XLEN-1){1'b0}}, op_a < ex.imm};
            XORI:  result = op_a ^ ex.imm;
            ORI:   result = op_a | ex.imm;
            ANDI:  result = op_a & ex.imm;
            SLLI:  result = op_a << ex.shamt;
            SRLI:  result = op_a >> ex.shamt;
            SRAI:  result = $signed(op_a) >>> ex.shamt;
            ADD:   result = op_a + op_b;
            SUB:   result = op_a - op_b;
            SLL:   result = op_a << op_b[4:0];
            SLT:   result = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            SLTU:  result = {{(XLEN-1){1'b0}}, op_a < op_b};
            XOR:   result = op_a ^ op_b;
            OR:    result = op_a | op_b;
            AND:   result = op_a & op_b;
            SRL:   result = op_a >> op_b[4:0];
            SRA:   result = $signed(op_a) >>> op_b[4:0];
            CLZ:   result = count_lead_zeros(op_a);
            CTZ:   result = count_trail_zeros(op_a);
            CPOP:  result = count_ones(op_a);
            default: ;
        endcase
    end

    // Zero-cycle stage
    assign res_o.valid   = ex_i.valid;
    assign ex_i.ready    = res_o.ready;
    assign res_o.payload = '{rd: ex.rd, result: result, we: ex.we};

endmodule
